// ==== bench/clock_gen.sv ====
module clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic nrst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release lines up with the stimulus offset
	initial
	begin
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 nrst = 1'b1;
	end

endmodule

// ==== bench/tb_csr_tasks.svh ====
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// all stimulus changes 2 ns after the rising edge
task automatic next_cycle();
	@(posedge clk);
	#2;
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		word_errors++;
	end
endtask

task automatic check_mode(input string name, input priv_mode_e got, input priv_mode_e exp);
	if (got !== exp)
	begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		mode_errors++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("Fail %s: got %h expected %h", name, got, exp);
		bit_errors++;
	end
endtask

// mstatus bit positions from the privileged spec
function automatic logic [31:0] status_word(input logic sie, input logic mie, input logic spie,
	input logic mpie, input logic spp, input logic sum, input priv_mode_e mpp);
	logic [31:0] w;
	w        = '0;
	w[1]     = sie;
	w[3]     = mie;
	w[5]     = spie;
	w[7]     = mpie;
	w[8]     = spp;
	w[12:11] = mpp;
	w[18]    = sum;
	return w;
endfunction

task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
	csr_we         = 1'b1;
	csr_address_wb = addr;
	csr_wb         = data;
	next_cycle();
	csr_we = 1'b0;
endtask

// combinational read, sampled mid cycle
task automatic expect_csr(input string name, input csr_addr_e addr, input logic [31:0] exp);
	csr_address_r = addr;
	#5;
	check_word(name, csr_data, exp);
	next_cycle();
endtask

task automatic test_reset();
	check_mode("current_mode", current_mode, PRIV_M);
	check_bit("illegal_ret", illegal_ret, 1'b0);
	check_bit("m_eie", m_eie, 1'b0);
	check_bit("m_tie", m_tie, 1'b0);
	check_bit("s_eie", s_eie, 1'b0);
	check_bit("s_tie", s_tie, 1'b0);
	expect_csr("mstatus", CSR_MSTATUS, status_word(0, 0, 0, 0, 0, 0, PRIV_M));
	expect_csr("misa", CSR_MISA, MISA_VALUE);
	expect_csr("mhartid", CSR_MHARTID, HART_ID);
endtask

task automatic test_write_read();
	logic [31:0] r;
	r = $urandom;
	csr_write(CSR_MSCRATCH, r);
	expect_csr("mscratch", CSR_MSCRATCH, r);
	r = $urandom;
	csr_write(CSR_SSCRATCH, r);
	expect_csr("sscratch", CSR_SSCRATCH, r);
	r = $urandom;
	csr_write(CSR_MEPC, r);
	expect_csr("mepc", CSR_MEPC, r & 32'hffff_fffc);
	// sstatus reaches sie, spie, spp and sum only
	csr_write(CSR_SSTATUS, 32'hffff_ffff);
	expect_csr("mstatus", CSR_MSTATUS, status_word(1, 0, 1, 0, 1, 1, PRIV_M));
	csr_write(CSR_MSTATUS, status_word(0, 0, 0, 0, 0, 0, PRIV_M));
	r = $urandom;
	csr_write(CSR_MSCRATCH, r);
	csr_we            = 1'b1;  // write colliding with a trap
	csr_address_wb    = CSR_MSCRATCH;
	csr_wb            = ~r;
	exception_pending = 1'b1;
	cause             = {1'b0, EXC_BREAKPOINT};
	pc_exc            = $urandom;
	next_cycle();
	csr_we            = 1'b0;
	exception_pending = 1'b0;
	expect_csr("mscratch", CSR_MSCRATCH, r);
endtask

task automatic test_trap_m();
	logic [31:0] tvec;
	logic [31:0] pc;
	tvec = $urandom & 32'hffff_fffc;
	pc   = $urandom;
	csr_write(CSR_MTVEC, tvec);
	csr_write(CSR_MSTATUS, status_word(0, 1, 0, 0, 0, 0, PRIV_M));
	exception_pending = 1'b1;
	cause             = {1'b0, EXC_I_ADDR_MISALIGNED};
	pc_exc            = pc;
	#5;
	check_word("epc", epc, tvec);
	next_cycle();
	exception_pending = 1'b0;
	check_mode("current_mode", current_mode, PRIV_M);
	expect_csr("mepc", CSR_MEPC, pc & 32'hffff_fffc);
	expect_csr("mcause", CSR_MCAUSE, {1'b0, EXC_I_ADDR_MISALIGNED});
	expect_csr("mtval", CSR_MTVAL, pc & 32'hffff_fffe);
	expect_csr("mstatus", CSR_MSTATUS, status_word(0, 0, 0, 1, 0, 0, PRIV_M));
	m_ret = 1'b1;
	#5;
	check_word("epc", epc, pc & 32'hffff_fffc);
	check_bit("illegal_ret", illegal_ret, 1'b0);
	next_cycle();
	m_ret = 1'b0;
	check_mode("current_mode", current_mode, PRIV_M);  // mpp was M
endtask

task automatic test_deleg_sret();
	logic [31:0] tvec;
	logic [31:0] pc;
	tvec = $urandom & 32'hffff_fffc;
	pc   = $urandom;
	csr_write(CSR_MEDELEG, 32'h1 << EXC_ILLEGAL_INSTR);
	csr_write(CSR_STVEC, tvec);
	csr_write(CSR_MSTATUS, status_word(0, 0, 0, 0, 0, 0, PRIV_U));
	m_ret = 1'b1;
	next_cycle();
	m_ret = 1'b0;
	check_mode("current_mode", current_mode, PRIV_U);
	exception_pending = 1'b1;
	cause             = {1'b0, EXC_ILLEGAL_INSTR};
	pc_exc            = pc;
	#5;
	check_word("epc", epc, tvec);  // delegated, so stvec
	next_cycle();
	exception_pending = 1'b0;
	check_mode("current_mode", current_mode, PRIV_S);
	expect_csr("sepc", CSR_SEPC, pc & 32'hffff_fffc);
	expect_csr("scause", CSR_SCAUSE, {1'b0, EXC_ILLEGAL_INSTR});
	expect_csr("stval", CSR_STVAL, 32'h0);
	s_ret = 1'b1;
	#5;
	check_word("epc", epc, pc & 32'hffff_fffc);
	next_cycle();
	check_mode("current_mode", current_mode, PRIV_U);
	// s_ret still high, now issued from U
	#5;
	check_bit("illegal_ret", illegal_ret, 1'b1);
	next_cycle();
	s_ret = 1'b0;
	check_mode("current_mode", current_mode, PRIV_U);
endtask

task automatic test_timer_enables();
	logic [31:0] t;
	int          i;
	csr_address_r = CSR_TIME;
	#5;
	t = csr_data;
	next_cycle();
	csr_write(CSR_MNECYCLE, t + 32'd40);
	next_cycle();  // flag is registered, old compare shows one more cycle
	check_bit("m_timer", m_timer, 1'b0);
	for (i = 0; i < 60 && !m_timer; i++)
		next_cycle();
	if (!m_timer)
	begin
		$display("m_timer did not rise within 60 cycles after the compare write");
		other_errors++;
	end
	for (i = 0; i < 4; i++)
	begin
		csr_write(CSR_MIE, i[0] ? 32'h80 : 32'h0);  // mtie
		csr_write(CSR_MSTATUS, status_word(0, i[1], 0, 0, 0, 0, PRIV_M));
		check_bit("m_tie", m_tie, i[0] & i[1]);
	end
	check_bit("s_timer", s_timer, 1'b1);  // stimecmp still 0 from reset
	csr_write(CSR_SNECYCLE, 32'hffff_ffff);
	next_cycle();
	check_bit("s_timer", s_timer, 1'b0);
endtask

`endif

// ==== bench/tb_csr_file.sv ====
module tb_csr_file
	import csr_arch_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int HART_ID      = 5;
	// per test: reset, write/read, trap m, delegation, timer
	localparam int BUDGET_CYCLES = 10 + 30 + 30 + 30 + 100;
	localparam int MARGIN_CYCLES = 50;

	logic        clk;
	logic        nrst;
	logic        csr_we;
	logic [11:0] csr_address_r;
	logic [11:0] csr_address_wb;
	logic [31:0] csr_wb;
	logic        exception_pending;
	logic [31:0] cause;
	logic [31:0] pc_exc;
	logic        m_ret;
	logic        s_ret;
	logic        m_interrupt;
	logic        s_interrupt;
	logic [31:0] csr_data;
	logic        m_timer;
	logic        s_timer;
	logic        m_eie;
	logic        m_tie;
	logic        s_eie;
	logic        s_tie;
	priv_mode_e  current_mode;
	logic        illegal_ret;
	logic [31:0] epc;

	int          word_errors;
	int          mode_errors;
	int          bit_errors;
	int          other_errors;
	int unsigned seed;

	clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.clk(clk), .nrst(nrst)
	);

	csr_file_top #(.TIME_W(64), .HART_ID(HART_ID)) DUT (
		.clk(clk), .nrst(nrst), .csr_we(csr_we), .csr_address_r(csr_address_r),
		.csr_address_wb(csr_address_wb), .csr_wb(csr_wb),
		.exception_pending(exception_pending), .cause(cause), .pc_exc(pc_exc),
		.m_ret(m_ret), .s_ret(s_ret), .m_interrupt(m_interrupt), .s_interrupt(s_interrupt),
		.csr_data(csr_data), .m_timer(m_timer), .s_timer(s_timer),
		.m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie),
		.current_mode(current_mode), .illegal_ret(illegal_ret), .epc(epc)
	);

	`include "tb_csr_tasks.svh"

	initial
	begin
		#((RESET_CYCLES + BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in its cycle budget");
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		seed              = $urandom(91771);
		word_errors       = 0;
		mode_errors       = 0;
		bit_errors        = 0;
		other_errors      = 0;
		csr_we            = 1'b0;
		csr_address_r     = '0;
		csr_address_wb    = '0;
		csr_wb            = '0;
		exception_pending = 1'b0;
		cause             = '0;
		pc_exc            = '0;
		m_ret             = 1'b0;
		s_ret             = 1'b0;
		m_interrupt       = 1'b0;
		s_interrupt       = 1'b0;
		@(posedge nrst);
		next_cycle();
		test_reset();
		test_write_read();
		test_trap_m();
		test_deleg_sret();
		test_timer_enables();
		$display("error counts: word %0d, mode %0d, bit %0d, other %0d",
			word_errors, mode_errors, bit_errors, other_errors);
		if (word_errors + mode_errors + bit_errors + other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+bench
verilog/csr_arch_pkg.sv
verilog/csr_types_pkg.sv
verilog/trap_ctrl.sv
verilog/status_regs.sv
verilog/trap_regs.sv
verilog/timer_unit.sv
verilog/csr_read_mux.sv
verilog/csr_file_top.sv
bench/clock_gen.sv
bench/tb_csr_file.sv

// ==== verilog/csr_arch_pkg.sv ====
package csr_arch_pkg;

	localparam int XLEN = 32;

	// addresses kept for M and S level trap handling
	typedef enum logic [11:0] {
		CSR_SSTATUS   = 12'h100,
		CSR_SIE       = 12'h104,
		CSR_STVEC     = 12'h105,
		CSR_SSCRATCH  = 12'h140,
		CSR_SEPC      = 12'h141,
		CSR_SCAUSE    = 12'h142,
		CSR_STVAL     = 12'h143,
		CSR_SIP       = 12'h144,
		CSR_MSTATUS   = 12'h300,
		CSR_MISA      = 12'h301,
		CSR_MEDELEG   = 12'h302,
		CSR_MIDELEG   = 12'h303,
		CSR_MIE       = 12'h304,
		CSR_MTVEC     = 12'h305,
		CSR_MSCRATCH  = 12'h340,
		CSR_MEPC      = 12'h341,
		CSR_MCAUSE    = 12'h342,
		CSR_MTVAL     = 12'h343,
		CSR_MIP       = 12'h344,
		CSR_SNECYCLE  = 12'h5c0,  // stimecmp
		CSR_MNECYCLE  = 12'hbbf,  // mtimecmp
		CSR_CYCLE     = 12'hc00,
		CSR_TIME      = 12'hc01,
		CSR_CYCLEH    = 12'hc80,
		CSR_TIMEH     = 12'hc81,
		CSR_MVENDORID = 12'hf11,
		CSR_MARCHID   = 12'hf12,
		CSR_MIMPID    = 12'hf13,
		CSR_MHARTID   = 12'hf14
	} csr_addr_e;

	// 2'b10 is reserved and never held
	typedef enum logic [1:0] {
		PRIV_U = 2'b00,
		PRIV_S = 2'b01,
		PRIV_M = 2'b11
	} priv_mode_e;

	// synchronous cause codes
	localparam logic [30:0] EXC_I_ADDR_MISALIGNED = 31'd0;
	localparam logic [30:0] EXC_I_ACCESS_FAULT    = 31'd1;
	localparam logic [30:0] EXC_ILLEGAL_INSTR     = 31'd2;
	localparam logic [30:0] EXC_BREAKPOINT        = 31'd3;
	localparam logic [30:0] EXC_L_ADDR_MISALIGNED = 31'd4;
	localparam logic [30:0] EXC_L_ACCESS_FAULT    = 31'd5;
	localparam logic [30:0] EXC_S_ADDR_MISALIGNED = 31'd6;
	localparam logic [30:0] EXC_S_ACCESS_FAULT    = 31'd7;
	localparam logic [30:0] EXC_ECALL_U           = 31'd8;
	localparam logic [30:0] EXC_ECALL_S           = 31'd9;
	localparam logic [30:0] EXC_ECALL_M           = 31'd11;

	// interrupt codes, with the cause msb set
	localparam logic [30:0] IRQ_S_TIMER = 31'd5;
	localparam logic [30:0] IRQ_M_TIMER = 31'd7;
	localparam logic [30:0] IRQ_S_EXT   = 31'd9;
	localparam logic [30:0] IRQ_M_EXT   = 31'd11;

	// MXL=1, extensions I M S U
	localparam logic [31:0] MISA_VALUE = {2'b01, 4'b0000, 26'b00000101000001000100000000};

endpackage

// ==== verilog/csr_file_top.sv ====
module csr_file_top
	import csr_arch_pkg::*;
	import csr_types_pkg::*;
#(
	parameter int TIME_W  = 64,
	parameter int HART_ID = 0
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        csr_we,
	input  logic [11:0] csr_address_r,
	input  logic [11:0] csr_address_wb,
	input  logic [31:0] csr_wb,
	input  logic        exception_pending,
	input  logic [31:0] cause,
	input  logic [31:0] pc_exc,
	input  logic        m_ret,
	input  logic        s_ret,
	input  logic        m_interrupt,
	input  logic        s_interrupt,
	output logic [31:0] csr_data,
	output logic        m_timer,
	output logic        s_timer,
	output logic        m_eie,
	output logic        m_tie,
	output logic        s_eie,
	output logic        s_tie,
	output priv_mode_e  current_mode,
	output logic        illegal_ret,
	output logic [31:0] epc
);

	csr_wr_t    wr;
	csr_wr_t    wr_q;   // write strobe after trap/return qualification
	trap_info_t trap;
	trap_evt_t  evt;
	status_t    status;
	deleg_t     deleg;
	trap_regs_t regs;
	time_t      time_rd;
	priv_mode_e target_mode;

	assign wr.we       = csr_we;
	assign wr.addr     = csr_addr_e'(csr_address_wb);
	assign wr.data.raw = csr_wb;

	assign trap.cause.raw = cause;
	assign trap.pc        = pc_exc;

	trap_ctrl u_trap_ctrl (
		.clk(clk), .nrst(nrst), .wr(wr), .trap(trap),
		.exception_pending(exception_pending), .m_ret(m_ret), .s_ret(s_ret),
		.status(status), .evt(evt), .wr_q(wr_q), .current_mode(current_mode),
		.illegal_ret(illegal_ret), .target_mode(target_mode), .deleg(deleg)
	);

	status_regs u_status_regs (
		.clk(clk), .nrst(nrst), .wr_q(wr_q), .evt(evt), .mode(current_mode),
		.status(status), .m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie)
	);

	trap_regs u_trap_regs (
		.clk(clk), .nrst(nrst), .wr_q(wr_q), .evt(evt), .trap(trap),
		.target_mode(target_mode), .m_ret(m_ret), .s_ret(s_ret),
		.regs(regs), .epc(epc)
	);

	timer_unit #(.TIME_W(TIME_W)) u_timer_unit (
		.clk(clk), .nrst(nrst), .wr_q(wr_q),
		.time_rd(time_rd), .m_timer(m_timer), .s_timer(s_timer)
	);

	csr_read_mux #(.TIME_W(TIME_W), .HART_ID(HART_ID)) u_csr_read_mux (
		.csr_address_r(csr_address_r), .status(status), .regs(regs), .deleg(deleg),
		.time_rd(time_rd), .m_interrupt(m_interrupt), .s_interrupt(s_interrupt),
		.m_timer(m_timer), .s_timer(s_timer), .csr_data(csr_data)
	);

endmodule

// ==== verilog/csr_read_mux.sv ====
module csr_read_mux
	import csr_arch_pkg::*;
	import csr_types_pkg::*;
#(
	parameter int TIME_W  = 64,
	parameter int HART_ID = 0
) (
	input  logic            [11:0] csr_address_r,
	input  status_t                status,
	input  trap_regs_t             regs,
	input  deleg_t                 deleg,
	input  time_t                  time_rd,
	input  logic                   m_interrupt,
	input  logic                   s_interrupt,
	input  logic                   m_timer,
	input  logic                   s_timer,
	output logic [XLEN-1:0]        csr_data
);

	csr_word_u   mstatus_w;
	csr_word_u   sstatus_w;
	csr_word_u   mie_w;
	csr_word_u   sie_w;
	csr_word_u   mip_w;
	csr_word_u   sip_w;
	logic [63:0] time_full;

	// only the live counter bits
	assign time_full = 64'(time_rd.mtime[TIME_W-1:0]);

	always_comb
	begin
		mstatus_w              = '0;
		mstatus_w.mstatus.sie  = status.sie;
		mstatus_w.mstatus.mie  = status.mie;
		mstatus_w.mstatus.spie = status.spie;
		mstatus_w.mstatus.mpie = status.mpie;
		mstatus_w.mstatus.spp  = status.spp;
		mstatus_w.mstatus.mpp  = status.mpp;
		mstatus_w.mstatus.sum  = status.sum;

		sstatus_w              = '0;  // restricted view
		sstatus_w.mstatus.sie  = status.sie;
		sstatus_w.mstatus.spie = status.spie;
		sstatus_w.mstatus.spp  = status.spp;
		sstatus_w.mstatus.sum  = status.sum;

		mie_w         = '0;
		mie_w.ie.meie = status.meie;
		mie_w.ie.seie = status.seie;
		mie_w.ie.mtie = status.mtie;
		mie_w.ie.stie = status.stie;

		sie_w         = '0;
		sie_w.ie.seie = status.seie;
		sie_w.ie.stie = status.stie;

		mip_w         = '0;  // pending bits share the enable positions
		mip_w.ie.meie = m_interrupt;
		mip_w.ie.seie = s_interrupt;
		mip_w.ie.mtie = m_timer;
		mip_w.ie.stie = s_timer;

		sip_w         = '0;
		sip_w.ie.seie = s_interrupt;
		sip_w.ie.stie = s_timer;
	end

	always_comb
	begin
		case (csr_address_r)
			CSR_MISA:                csr_data = MISA_VALUE;
			CSR_MVENDORID,
			CSR_MARCHID,
			CSR_MIMPID:              csr_data = '0;
			CSR_MHARTID:             csr_data = XLEN'(HART_ID);
			CSR_MSTATUS:             csr_data = mstatus_w.raw;
			CSR_SSTATUS:             csr_data = sstatus_w.raw;
			CSR_MIE:                 csr_data = mie_w.raw;
			CSR_SIE:                 csr_data = sie_w.raw;
			CSR_MIP:                 csr_data = mip_w.raw;
			CSR_SIP:                 csr_data = sip_w.raw;
			CSR_MEDELEG:             csr_data = XLEN'(deleg.medeleg);
			CSR_MIDELEG:             csr_data = XLEN'(deleg.mideleg);
			CSR_MTVEC:               csr_data = regs.mtvec;
			CSR_STVEC:               csr_data = regs.stvec;
			CSR_MEPC:                csr_data = regs.mepc;
			CSR_SEPC:                csr_data = regs.sepc;
			CSR_MCAUSE:              csr_data = regs.mcause.raw;
			CSR_SCAUSE:              csr_data = regs.scause.raw;
			CSR_MTVAL:               csr_data = regs.mtval;
			CSR_STVAL:               csr_data = regs.stval;
			CSR_MSCRATCH:            csr_data = regs.mscratch;
			CSR_SSCRATCH:            csr_data = regs.sscratch;
			CSR_MNECYCLE:            csr_data = time_rd.mtimecmp;
			CSR_SNECYCLE:            csr_data = time_rd.stimecmp;
			CSR_TIME, CSR_CYCLE:     csr_data = time_full[31:0];
			CSR_TIMEH, CSR_CYCLEH:   csr_data = time_full[63:32];
			default:                 csr_data = '0;  // unimplemented
		endcase
	end

endmodule

// ==== verilog/csr_types_pkg.sv ====
package csr_types_pkg;
	import csr_arch_pkg::*;

	typedef struct packed {
		logic [12:0] rsv19;
		logic        sum;
		logic [4:0]  rsv13;
		logic [1:0]  mpp;
		logic [1:0]  rsv9;
		logic        spp;
		logic        mpie;
		logic        rsv6;
		logic        spie;
		logic        rsv4;   // upie, no N extension
		logic        mie;
		logic        rsv2;
		logic        sie;
		logic        uie;
	} mstatus_t;

	// same bit positions for mie/sie and mip/sip
	typedef struct packed {
		logic [19:0] rsv12;
		logic        meie;
		logic        rsv10;
		logic        seie;
		logic        rsv8;
		logic        mtie;
		logic        rsv6;
		logic        stie;
		logic [4:0]  rsv0;
	} ie_t;

	typedef struct packed {
		logic        irq;
		logic [30:0] code;
	} cause_t;

	typedef union packed {
		logic [XLEN-1:0] raw;
		mstatus_t        mstatus;
		ie_t             ie;
		cause_t          cause;
	} csr_word_u;

	typedef struct packed {
		logic      we;
		csr_addr_e addr;
		csr_word_u data;
	} csr_wr_t;

	typedef struct packed {
		csr_word_u       cause;
		logic [XLEN-1:0] pc;
	} trap_info_t;

	// at most one strobe per cycle
	typedef struct packed {
		logic take_m;
		logic take_s;
		logic do_mret;
		logic do_sret;
	} trap_evt_t;

	typedef struct packed {
		logic       sum;
		priv_mode_e mpp;
		logic       spp;
		logic       mpie;
		logic       spie;
		logic       mie;
		logic       sie;
		logic       meie;
		logic       seie;
		logic       mtie;
		logic       stie;
	} status_t;

	typedef struct packed {
		logic [63:0]     mtime;
		logic [XLEN-1:0] mtimecmp;
		logic [XLEN-1:0] stimecmp;
	} time_t;

	typedef struct packed {
		logic [15:0] medeleg;
		logic [11:0] mideleg;
	} deleg_t;

	typedef struct packed {
		logic [XLEN-1:0] mtvec;
		logic [XLEN-1:0] stvec;
		logic [XLEN-1:0] mepc;
		logic [XLEN-1:0] sepc;
		csr_word_u       mcause;
		csr_word_u       scause;
		logic [XLEN-1:0] mtval;
		logic [XLEN-1:0] stval;
		logic [XLEN-1:0] mscratch;
		logic [XLEN-1:0] sscratch;
	} trap_regs_t;

endpackage

// ==== verilog/status_regs.sv ====
module status_regs
	import csr_arch_pkg::*;
	import csr_types_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  csr_wr_t    wr_q,
	input  trap_evt_t  evt,
	input  priv_mode_e mode,
	output status_t    status,
	output logic       m_eie,
	output logic       m_tie,
	output logic       s_eie,
	output logic       s_tie
);

	csr_word_u d;

	assign d = wr_q.data;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			status <= '{sum: 1'b0, mpp: PRIV_M, spp: 1'b0, mpie: 1'b0, spie: 1'b0,
				mie: 1'b0, sie: 1'b0, meie: 1'b0, seie: 1'b0, mtie: 1'b0, stie: 1'b0};
		end
		else if (evt.take_m)
		begin
			status.mpie <= status.mie;  // push
			status.mie  <= 1'b0;
			status.mpp  <= mode;
		end
		else if (evt.take_s)
		begin
			status.spie <= status.sie;
			status.sie  <= 1'b0;
			status.spp  <= mode[0];
		end
		else if (evt.do_mret)
		begin
			status.mie  <= status.mpie;  // pop
			status.mpie <= 1'b1;
			status.mpp  <= PRIV_U;
		end
		else if (evt.do_sret)
		begin
			status.sie  <= status.spie;
			status.spie <= 1'b1;
			status.spp  <= 1'b0;
		end
		else if (wr_q.we)
		begin
			case (wr_q.addr)
				CSR_MSTATUS:
				begin
					status.sie  <= d.mstatus.sie;
					status.mie  <= d.mstatus.mie;
					status.spie <= d.mstatus.spie;
					status.mpie <= d.mstatus.mpie;
					status.spp  <= d.mstatus.spp;
					status.sum  <= d.mstatus.sum;
					if (d.mstatus.mpp != 2'b10)  // reserved value keeps old mpp
						status.mpp <= priv_mode_e'(d.mstatus.mpp);
				end
				CSR_SSTATUS:
				begin
					status.sie  <= d.mstatus.sie;
					status.spie <= d.mstatus.spie;
					status.spp  <= d.mstatus.spp;
					status.sum  <= d.mstatus.sum;
				end
				CSR_MIE:
				begin
					status.meie <= d.ie.meie;
					status.seie <= d.ie.seie;
					status.mtie <= d.ie.mtie;
					status.stie <= d.ie.stie;
				end
				CSR_SIE:
				begin
					status.seie <= d.ie.seie;
					status.stie <= d.ie.stie;
				end
				default: ;
			endcase
		end
	end

	// enables gated by the global xIE bits
	assign m_eie = status.meie && status.mie;
	assign m_tie = status.mtie && status.mie;
	assign s_eie = status.seie && status.sie;
	assign s_tie = status.stie && status.sie;

	a_mpp_legal: assert property (@(posedge clk) disable iff (!nrst)
		status.mpp != 2'b10);

endmodule

// ==== verilog/timer_unit.sv ====
module timer_unit
	import csr_arch_pkg::*;
	import csr_types_pkg::*;
#(
	parameter int TIME_W = 64
) (
	input  logic    clk,
	input  logic    nrst,
	input  csr_wr_t wr_q,
	output time_t   time_rd,
	output logic    m_timer,
	output logic    s_timer
);

	logic [TIME_W-1:0] mtime;
	logic [XLEN-1:0]   mtimecmp;
	logic [XLEN-1:0]   stimecmp;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mtime    <= '0;
			mtimecmp <= '0;
			stimecmp <= '0;
			m_timer  <= 1'b0;
			s_timer  <= 1'b0;
		end
		else
		begin
			mtime   <= mtime + 1'b1;  // free running
			m_timer <= mtime >= TIME_W'(mtimecmp);
			s_timer <= mtime >= TIME_W'(stimecmp);
			if (wr_q.we && wr_q.addr == CSR_MNECYCLE)
				mtimecmp <= wr_q.data.raw;
			if (wr_q.we && wr_q.addr == CSR_SNECYCLE)
				stimecmp <= wr_q.data.raw;
		end
	end

	assign time_rd.mtime    = 64'(mtime);
	assign time_rd.mtimecmp = mtimecmp;
	assign time_rd.stimecmp = stimecmp;

endmodule

// ==== verilog/trap_ctrl.sv ====
module trap_ctrl
	import csr_arch_pkg::*;
	import csr_types_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  csr_wr_t    wr,
	input  trap_info_t trap,
	input  logic       exception_pending,
	input  logic       m_ret,
	input  logic       s_ret,
	input  status_t    status,
	output trap_evt_t  evt,
	output csr_wr_t    wr_q,
	output priv_mode_e current_mode,
	output logic       illegal_ret,
	output priv_mode_e target_mode,
	output deleg_t     deleg
);

	logic       deleg_hit;
	priv_mode_e next_mode;

	// delegation bit picked by cause code, out of range codes never delegate
	always_comb
	begin
		if (trap.cause.cause.irq)
			deleg_hit = (trap.cause.cause.code < 31'd12) && deleg.mideleg[trap.cause.cause.code[3:0]];
		else
			deleg_hit = (trap.cause.cause.code < 31'd16) && deleg.medeleg[trap.cause.cause.code[3:0]];
	end

	// traps taken in M stay in M
	assign target_mode = (current_mode != PRIV_M && deleg_hit) ? PRIV_S : PRIV_M;

	assign illegal_ret = (m_ret && current_mode != PRIV_M) || (s_ret && current_mode == PRIV_U);

	assign evt.take_m  = exception_pending && target_mode == PRIV_M;
	assign evt.take_s  = exception_pending && target_mode == PRIV_S;
	assign evt.do_mret = m_ret && current_mode == PRIV_M;
	assign evt.do_sret = s_ret && current_mode != PRIV_U;

	// writes are dropped in trap and return cycles
	assign wr_q.we   = wr.we && !(exception_pending || m_ret || s_ret);
	assign wr_q.addr = wr.addr;
	assign wr_q.data = wr.data;

	always_comb
	begin
		next_mode = current_mode;
		if (evt.take_m)
			next_mode = PRIV_M;
		else if (evt.take_s)
			next_mode = PRIV_S;
		else if (evt.do_mret)
			next_mode = status.mpp;
		else if (evt.do_sret)
			next_mode = status.spp ? PRIV_S : PRIV_U;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= PRIV_M;  // hart comes up in M
			deleg        <= '0;
		end
		else
		begin
			current_mode <= next_mode;
			if (wr_q.we && wr_q.addr == CSR_MEDELEG)
				deleg.medeleg <= wr_q.data.raw[15:0];
			if (wr_q.we && wr_q.addr == CSR_MIDELEG)
				deleg.mideleg <= wr_q.data.raw[11:0];
		end
	end

	// the pipeline never sends a trap together with a return
	a_one_event: assert property (@(posedge clk) disable iff (!nrst)
		$onehot0({exception_pending, m_ret, s_ret}));

endmodule

// ==== verilog/trap_regs.sv ====
module trap_regs
	import csr_arch_pkg::*;
	import csr_types_pkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  csr_wr_t         wr_q,
	input  trap_evt_t       evt,
	input  trap_info_t      trap,
	input  priv_mode_e      target_mode,
	input  logic            m_ret,
	input  logic            s_ret,
	output trap_regs_t      regs,
	output logic [XLEN-1:0] epc
);

	logic [XLEN-1:0] tval;
	logic [XLEN-1:0] epc_cap;
	logic [XLEN-1:0] wdata;

	// only a misaligned fetch reports its address
	always_comb
	begin
		if (!trap.cause.cause.irq && trap.cause.cause.code == EXC_I_ADDR_MISALIGNED)
			tval = {trap.pc[XLEN-1:1], 1'b0};
		else
			tval = '0;
	end

	assign epc_cap = {trap.pc[XLEN-1:2], 2'b00};
	assign wdata   = wr_q.data.raw;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			regs <= '0;
		else if (evt.take_m)
		begin
			regs.mepc   <= epc_cap;
			regs.mcause <= trap.cause;
			regs.mtval  <= tval;
		end
		else if (evt.take_s)
		begin
			regs.sepc   <= epc_cap;
			regs.scause <= trap.cause;
			regs.stval  <= tval;
		end
		else if (wr_q.we)
		begin
			case (wr_q.addr)
				CSR_MTVEC:    regs.mtvec    <= {wdata[XLEN-1:2], 2'b00};  // direct mode only
				CSR_STVEC:    regs.stvec    <= {wdata[XLEN-1:2], 2'b00};
				CSR_MEPC:     regs.mepc     <= {wdata[XLEN-1:2], 2'b00};
				CSR_SEPC:     regs.sepc     <= {wdata[XLEN-1:2], 2'b00};
				CSR_MCAUSE:   regs.mcause   <= wr_q.data;
				CSR_SCAUSE:   regs.scause   <= wr_q.data;
				CSR_MTVAL:    regs.mtval    <= wdata;
				CSR_STVAL:    regs.stval    <= wdata;
				CSR_MSCRATCH: regs.mscratch <= wdata;
				CSR_SSCRATCH: regs.sscratch <= wdata;
				default: ;
			endcase
		end
	end

	// next fetch address for the front end
	always_comb
	begin
		if (m_ret)
			epc = regs.mepc;
		else if (s_ret)
			epc = regs.sepc;
		else if (target_mode == PRIV_S)
			epc = regs.stvec;
		else
			epc = regs.mtvec;
	end

endmodule
